// File: axis_framer.f
+incdir+.
axis_framer_stream_pkg.sv
axis_framer_cfg_pkg.sv
fifo_sync.sv
frame_cfg.sv
fifo2axis.sv
frame_stats.sv
axis_framer_top.sv
tb_axis_framer.sv

// File: axis_framer_cfg_pkg.sv
package axis_framer_cfg_pkg;

   // default frame length width
   localparam int LEN_W = 8;

   // payload of one configuration write
   typedef struct packed {
      logic             enable;
      logic [LEN_W-1:0] length;
   } cfg_word_t;

   // decoded configuration, err is sticky until reset
   typedef struct packed {
      logic             en;
      logic [LEN_W-1:0] len;
      logic             err;
   } cfg_state_t;

endpackage

// File: axis_framer_stream_pkg.sv
package axis_framer_stream_pkg;

   // default data word width, the top passes its own value down
   localparam int DATA_W = 16;

   // statistics counter widths
   localparam int BEAT_CNT_W  = 32;
   localparam int FRAME_CNT_W = 16;

   // one beat on the master stream port
   typedef struct packed {
      logic [DATA_W-1:0] tdata;
      logic              tlast;
   } axis_beat_t;

   // accepted traffic seen on the stream port
   typedef struct packed {
      logic [BEAT_CNT_W-1:0]  beat_count;
      logic [FRAME_CNT_W-1:0] frame_count;
      logic                   frame_open;
   } frame_stats_t;

endpackage

// File: axis_framer_top.sv
`timescale 1ns/10ps

module axis_framer_top
   import axis_framer_stream_pkg::*;
   import axis_framer_cfg_pkg::*;
#(
   parameter int DATA_W       = axis_framer_stream_pkg::DATA_W,
   parameter int LEN_W        = axis_framer_cfg_pkg::LEN_W,
   parameter int FIFO_DEPTH_W = 4
) (
   input  logic              clk_i,
   input  logic              reset_i,

   input  logic              wr_i,
   input  logic [DATA_W-1:0] wr_data_i,
   output logic              full_o,

   input  logic              cfg_wr_i,
   input  cfg_word_t         cfg_i,
   output cfg_state_t        cfg_o,

   output logic              m_axis_tvalid_o,
   output axis_beat_t        m_axis_o,
   input  logic              m_axis_tready_i,

   output frame_stats_t      stats_o
);

   logic              fifo_read;
   logic              fifo_empty;
   logic [DATA_W-1:0] fifo_rdata;

   fifo_sync #(
      .DATA_W      (DATA_W),
      .FIFO_DEPTH_W(FIFO_DEPTH_W)
   ) fifo_inst (
      .clk_i    (clk_i),
      .reset_i  (reset_i),
      .wr_i     (wr_i),
      .wr_data_i(wr_data_i),
      .rd_i     (fifo_read),
      .rd_data_o(fifo_rdata),
      .empty_o  (fifo_empty),
      .full_o   (full_o)
   );

   // length updates wait for the open frame to close
   frame_cfg #(
      .LEN_W(LEN_W)
   ) cfg_inst (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .cfg_wr_i    (cfg_wr_i),
      .cfg_i       (cfg_i),
      .frame_open_i(stats_o.frame_open),
      .cfg_o       (cfg_o)
   );

   fifo2axis #(
      .DATA_W(DATA_W),
      .LEN_W (LEN_W)
   ) framer_inst (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .cfg_i        (cfg_o),
      .fifo_empty_i (fifo_empty),
      .fifo_read_o  (fifo_read),
      .fifo_rdata_i (fifo_rdata),
      .axis_tvalid_o(m_axis_tvalid_o),
      .axis_o       (m_axis_o),
      .axis_tready_i(m_axis_tready_i)
   );

   frame_stats #(
      .LEN_W(LEN_W)
   ) stats_inst (
      .clk_i   (clk_i),
      .reset_i (reset_i),
      .tvalid_i(m_axis_tvalid_o),
      .tready_i(m_axis_tready_i),
      .beat_i  (m_axis_o),
      .stats_o (stats_o)
   );

endmodule

// File: fifo2axis.sv
`timescale 1ns/10ps

module fifo2axis
   import axis_framer_stream_pkg::*;
   import axis_framer_cfg_pkg::*;
#(
   parameter int DATA_W = axis_framer_stream_pkg::DATA_W,
   parameter int LEN_W  = axis_framer_cfg_pkg::LEN_W
) (
   input  logic              clk_i,
   input  logic              reset_i,
   input  cfg_state_t        cfg_i,

   input  logic              fifo_empty_i,
   output logic              fifo_read_o,
   input  logic [DATA_W-1:0] fifo_rdata_i,

   output logic              axis_tvalid_o,
   output axis_beat_t        axis_o,
   input  logic              axis_tready_i
);

   logic              pipe_en;
   logic              rd_valid_q;
   logic [LEN_W-1:0]  len_last;
   logic [LEN_W-1:0]  word_cnt_q;
   logic              rd_last;
   logic              save;
   logic              saved_q;
   logic [DATA_W-1:0] saved_data_q;
   logic              saved_last_q;
   logic              out_valid_nxt;
   logic [DATA_W-1:0] out_data_nxt;
   logic              out_last_nxt;
   logic              out_valid_q;
   logic [DATA_W-1:0] out_data_q;
   logic              out_last_q;

   assign pipe_en     = axis_tready_i & cfg_i.en;
   assign fifo_read_o = axis_tready_i & ~fifo_empty_i & cfg_i.en;

   // fifo data valid one cycle after the read
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rd_valid_q <= 1'b0;
      end else begin
         rd_valid_q <= fifo_read_o;
      end
   end

   assign len_last = cfg_i.len - 1'b1;
   assign rd_last  = (word_cnt_q == len_last);

   // all ones so the first read after enable counts as word 0
   always_ff @(posedge clk_i) begin
      if (reset_i || !cfg_i.en) begin
         word_cnt_q <= '1;
      end else if (fifo_read_o) begin
         word_cnt_q <= (word_cnt_q == len_last) ? '0 : word_cnt_q + 1'b1;
      end
   end

   // word read but output stalled, park it
   assign save = rd_valid_q & ~pipe_en;

   always_ff @(posedge clk_i) begin
      if (reset_i || pipe_en) begin
         saved_q <= 1'b0;
      end else if (rd_valid_q) begin
         saved_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_i) begin
      if (save) begin
         saved_data_q <= fifo_rdata_i;
         saved_last_q <= rd_last;
      end
   end

   // skid word goes out before fresh fifo data
   always_comb begin
      if (saved_q) begin
         out_valid_nxt = 1'b1;
         out_data_nxt  = saved_data_q;
         out_last_nxt  = saved_last_q;
      end else begin
         out_valid_nxt = rd_valid_q;
         out_data_nxt  = fifo_rdata_i;
         out_last_nxt  = rd_valid_q & rd_last;
      end
   end

   // output pipeline register
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         out_valid_q <= 1'b0;
         out_last_q  <= 1'b0;
      end else if (pipe_en) begin
         out_valid_q <= out_valid_nxt;
         out_last_q  <= out_last_nxt;
      end
   end

   always_ff @(posedge clk_i) begin
      if (pipe_en) begin
         out_data_q <= out_data_nxt;
      end
   end

   assign axis_tvalid_o = out_valid_q;
   assign axis_o        = '{tdata: out_data_q, tlast: out_last_q};

endmodule

// File: fifo_sync.sv
`timescale 1ns/10ps

module fifo_sync #(
   parameter int DATA_W       = axis_framer_stream_pkg::DATA_W,
   parameter int FIFO_DEPTH_W = 4
) (
   input  logic              clk_i,
   input  logic              reset_i,
   input  logic              wr_i,
   input  logic [DATA_W-1:0] wr_data_i,
   input  logic              rd_i,
   output logic [DATA_W-1:0] rd_data_o,
   output logic              empty_o,
   output logic              full_o
);

   localparam int DEPTH = 2 ** FIFO_DEPTH_W;

   logic [DATA_W-1:0]       mem [DEPTH];
   logic [FIFO_DEPTH_W-1:0] wr_ptr;
   logic [FIFO_DEPTH_W-1:0] rd_ptr;
   logic [FIFO_DEPTH_W:0]   level;
   logic                    do_wr;
   logic                    do_rd;

   // writes when full and reads when empty are ignored
   assign do_wr   = wr_i & ~full_o;
   assign do_rd   = rd_i & ~empty_o;
   assign empty_o = (level == '0);
   assign full_o  = (level == (FIFO_DEPTH_W + 1)'(DEPTH));

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         level  <= '0;
      end else begin
         if (do_wr) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({do_wr, do_rd})
            2'b10:   level <= level + 1'b1;
            2'b01:   level <= level - 1'b1;
            default: level <= level;
         endcase
      end
   end

   always_ff @(posedge clk_i) begin
      if (do_wr) begin
         mem[wr_ptr] <= wr_data_i;
      end
   end

   // read data lands one cycle after the read pulse
   always_ff @(posedge clk_i) begin
      if (do_rd) begin
         rd_data_o <= mem[rd_ptr];
      end
   end

endmodule

// File: frame_cfg.sv
`timescale 1ns/10ps

module frame_cfg
   import axis_framer_cfg_pkg::*;
#(
   parameter int LEN_W = axis_framer_cfg_pkg::LEN_W
) (
   input  logic       clk_i,
   input  logic       reset_i,
   input  logic       cfg_wr_i,
   input  cfg_word_t  cfg_i,
   input  logic       frame_open_i,
   output cfg_state_t cfg_o
);

   logic             en_q;
   logic [LEN_W-1:0] len_q;
   logic             err_q;
   logic             len_zero;
   logic             len_free;

   assign len_zero = (cfg_i.length == '0);

   // length only moves while stopped and between frames
   assign len_free = ~en_q & ~frame_open_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         en_q  <= 1'b0;
         len_q <= LEN_W'(1);
         err_q <= 1'b0;
      end else if (cfg_wr_i) begin
         en_q <= cfg_i.enable;
         if (len_zero) begin
            // zero length never reaches the framer
            err_q <= 1'b1;
         end else if (len_free) begin
            len_q <= cfg_i.length;
         end
      end
   end

   assign cfg_o = '{en: en_q, len: len_q, err: err_q};

endmodule

// File: frame_stats.sv
`timescale 1ns/10ps

module frame_stats
   import axis_framer_stream_pkg::*;
#(
   parameter int LEN_W = axis_framer_cfg_pkg::LEN_W
) (
   input  logic         clk_i,
   input  logic         reset_i,
   input  logic         tvalid_i,
   input  logic         tready_i,
   input  axis_beat_t   beat_i,
   output frame_stats_t stats_o
);

   logic                   accept;
   logic [BEAT_CNT_W-1:0]  beat_cnt_q;
   logic [FRAME_CNT_W-1:0] frame_cnt_q;
   logic [LEN_W-1:0]       open_beats_q;

   assign accept = tvalid_i & tready_i;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         beat_cnt_q   <= '0;
         frame_cnt_q  <= '0;
         open_beats_q <= '0;
      end else if (accept) begin
         beat_cnt_q <= beat_cnt_q + 1'b1;
         if (beat_i.tlast) begin
            frame_cnt_q  <= frame_cnt_q + 1'b1;
            open_beats_q <= '0;
         end else if (open_beats_q != '1) begin
            // saturate so a long open frame never reads as closed
            open_beats_q <= open_beats_q + 1'b1;
         end
      end
   end

   assign stats_o = '{
      beat_count:  beat_cnt_q,
      frame_count: frame_cnt_q,
      frame_open:  (open_beats_q != '0)
   };

endmodule

// File: run_sim.sh
#!/bin/sh
# build and run the axis_framer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f axis_framer.f --top-module tb_axis_framer \
   -Mdir obj_dir -o sim_axis_framer
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_axis_framer > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^PASS: all tests$" sim.log; then
   exit 0
fi
echo "pass message not found in sim.log"
exit 1

// File: tb_axis_framer_tasks.svh
task automatic compare_beat(input axis_beat_t got, input axis_beat_t exp, input string what);
   if (got !== exp) begin
      $display("Fail at %0t: %s got data %h last %0b, expected data %h last %0b",
               $time, what, got.tdata, got.tlast, exp.tdata, exp.tlast);
      beat_errs++;
   end
endtask

task automatic compare_cfg(input cfg_state_t got, input cfg_state_t exp, input string what);
   if (got !== exp) begin
      $display("Fail at %0t: %s got en %0b len %0d err %0b, expected en %0b len %0d err %0b",
               $time, what, got.en, got.len, got.err, exp.en, exp.len, exp.err);
      cfg_errs++;
   end
endtask

task automatic compare_stats(input frame_stats_t got, input frame_stats_t exp,
                             input string what);
   if (got !== exp) begin
      $display("Fail at %0t: %s got beats %0d frames %0d open %0b, expected %0d %0d %0b",
               $time, what, got.beat_count, got.frame_count, got.frame_open,
               exp.beat_count, exp.frame_count, exp.frame_open);
      stats_errs++;
   end
endtask

// one word per cycle, expected beats follow the tlast rule
task automatic write_words(input int count, input logic [DATA_W-1:0] base);
   axis_beat_t beat;
   int         i;
   for (i = 0; i < count; i++) begin
      @(posedge clk_i);
      #1;
      wr_i       = 1'b1;
      wr_data_i  = base + DATA_W'(i);
      beat.tdata = base + DATA_W'(i);
      beat.tlast = ((model_idx + 1) % model_len == 0);
      exp_q.push_back(beat);
      model_idx++;
      exp_beats++;
      if (beat.tlast) begin
         exp_frames++;
      end
      model_open = ~beat.tlast;
   end
   @(posedge clk_i);
   #1;
   wr_i = 1'b0;
endtask

task automatic configure(input logic enable, input int length);
   cfg_word_t word;
   word.enable = enable;
   word.length = LEN_W'(length);
   // length moves only while stopped with no open frame, zero is an error
   if (length == 0) begin
      exp_cfg.err = 1'b1;
   end else if (!exp_cfg.en && !model_open) begin
      exp_cfg.len = LEN_W'(length);
      model_len   = length;
   end
   exp_cfg.en = enable;
   if (!enable) begin
      model_idx = 0;
   end
   @(posedge clk_i);
   #1;
   cfg_wr_i = 1'b1;
   cfg_i    = word;
   @(posedge clk_i);
   #1;
   cfg_wr_i = 1'b0;
   compare_cfg(cfg_o, exp_cfg, $sformatf("config write en %0b len %0d", enable, length));
endtask

// waits for the expected beats, then checks for extras
task automatic check_stream(input string name);
   axis_beat_t exp;
   int         waited;
   int         idx;
   int         limit;
   waited = 0;
   limit  = exp_q.size() * 20;
   while (got_q.size() - got_base < exp_q.size() && waited < limit) begin
      @(posedge clk_i);
      #1;
      waited++;
   end
   repeat (5) @(posedge clk_i);
   #1;
   if (got_q.size() - got_base != exp_q.size()) begin
      $display("%s: %0d beats arrived but %0d were expected",
               name, got_q.size() - got_base, exp_q.size());
      other_errs++;
   end
   idx = 0;
   while (exp_q.size() > 0) begin
      exp = exp_q.pop_front();
      if (got_base + idx < got_q.size()) begin
         compare_beat(got_q[got_base + idx], exp, $sformatf("%s beat %0d", name, idx));
      end
      idx++;
   end
   got_base = got_q.size();
endtask

task automatic watch_first_valid();
   first_lat = 0;
   @(posedge clk_i);
   #1;
   while (!m_axis_tvalid_o && first_lat < 20) begin
      @(posedge clk_i);
      #1;
      first_lat++;
   end
endtask

task automatic check_after_reset();
   frame_stats_t zero_stats;
   zero_stats = '0;
   if (m_axis_tvalid_o !== 1'b0) begin
      $display("Fail at %0t: tvalid high after reset", $time);
      other_errs++;
   end
   compare_cfg(cfg_o, exp_cfg, "after reset");
   compare_stats(stats_o, zero_stats, "after reset");
endtask

task automatic run_single_frame();
   configure(1'b1, 4);
   fork
      write_words(4, 16'h1100);
      watch_first_valid();
   join
   if (first_lat != 3) begin
      $display("Fail at %0t: first beat %0d cycles after its write, expected 3",
               $time, first_lat);
      other_errs++;
   end
   check_stream("single frame");
endtask

task automatic run_backpressure();
   configure(1'b0, 3);
   configure(1'b1, 3);
   @(negedge clk_i);
   rand_ready = 1'b1;
   write_words(12, 16'h2200);
   check_stream("back-pressure");
   @(negedge clk_i);
   rand_ready = 1'b0;
endtask

task automatic check_cfg_rules();
   // change while enabled, err still clear
   configure(1'b1, 5);
   configure(1'b0, 3);
   // zero length while stopped and between frames
   configure(1'b1, 0);
   configure(1'b0, 6);
   configure(1'b1, 2);
   write_words(4, 16'h3300);
   check_stream("new length");
endtask

// fill while stopped so nothing drains
task automatic check_fifo_full();
   configure(1'b0, 2);
   write_words(FIFO_DEPTH, 16'h4400);
   if (full_o !== 1'b1) begin
      $display("Fail at %0t: full_o low after %0d writes", $time, FIFO_DEPTH);
      other_errs++;
   end
   // this word is dropped
   wr_i      = 1'b1;
   wr_data_i = 16'h44ff;
   @(posedge clk_i);
   #1;
   wr_i = 1'b0;
   configure(1'b1, 2);
   check_stream("fifo full");
endtask

task automatic check_final_stats();
   frame_stats_t exp;
   exp.beat_count  = BEAT_CNT_W'(exp_beats);
   exp.frame_count = FRAME_CNT_W'(exp_frames);
   exp.frame_open  = 1'b0;
   compare_stats(stats_o, exp, "final totals");
endtask

// File: tb_axis_framer.sv
`timescale 1ns/10ps

module tb_axis_framer
   import axis_framer_stream_pkg::*;
   import axis_framer_cfg_pkg::*;
();

   localparam int FIFO_DEPTH_W    = 4;
   localparam int FIFO_DEPTH      = 2 ** FIFO_DEPTH_W;
   // 20 cycles per written word plus reset and configuration margin
   localparam int TOTAL_WORDS     = 4 + 12 + 4 + FIFO_DEPTH + 1;
   localparam int WATCHDOG_CYCLES = 8 + TOTAL_WORDS * 20 + 200;

   logic              clk_i = 1'b0;
   logic              reset_i;
   logic              wr_i;
   logic [DATA_W-1:0] wr_data_i;
   logic              full_o;
   logic              cfg_wr_i;
   cfg_word_t         cfg_i;
   cfg_state_t        cfg_o;
   logic              m_axis_tvalid_o;
   axis_beat_t        m_axis_o;
   logic              m_axis_tready_i = 1'b1;
   frame_stats_t      stats_o;

   axis_beat_t got_q[$];
   axis_beat_t exp_q[$];
   int         got_base = 0;
   cfg_state_t exp_cfg;
   int         model_len;
   int         model_idx;
   logic       model_open;
   int         exp_beats;
   int         exp_frames;
   int         first_lat;
   logic       rand_ready = 1'b0;
   int         seed = 32'h7b17;
   int         rnd;
   int         beat_errs;
   int         cfg_errs;
   int         stats_errs;
   int         other_errs;

   always #50 clk_i = ~clk_i;

   axis_framer_top #(
      .DATA_W      (DATA_W),
      .LEN_W       (LEN_W),
      .FIFO_DEPTH_W(FIFO_DEPTH_W)
   ) DUT (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .wr_i           (wr_i),
      .wr_data_i      (wr_data_i),
      .full_o         (full_o),
      .cfg_wr_i       (cfg_wr_i),
      .cfg_i          (cfg_i),
      .cfg_o          (cfg_o),
      .m_axis_tvalid_o(m_axis_tvalid_o),
      .m_axis_o       (m_axis_o),
      .m_axis_tready_i(m_axis_tready_i),
      .stats_o        (stats_o)
   );

   // every accepted beat
   always @(posedge clk_i) begin
      if (!reset_i && m_axis_tvalid_o && m_axis_tready_i) begin
         got_q.push_back(m_axis_o);
      end
   end

   // ready is random only while back-pressure is on
   always @(posedge clk_i) begin
      #1;
      rnd = $random(seed);
      m_axis_tready_i = rand_ready ? rnd[0] : 1'b1;
   end

   initial begin
      repeat (WATCHDOG_CYCLES) @(posedge clk_i);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("FAIL: see errors above");
      $finish;
   end

   `include "tb_axis_framer_tasks.svh"

   initial begin
      reset_i    = 1'b1;
      wr_i       = 1'b0;
      wr_data_i  = '0;
      cfg_wr_i   = 1'b0;
      cfg_i      = '0;
      exp_cfg    = '{en: 1'b0, len: LEN_W'(1), err: 1'b0};
      model_len  = 1;
      model_idx  = 0;
      model_open = 1'b0;
      exp_beats  = 0;
      exp_frames = 0;
      beat_errs  = 0;
      cfg_errs   = 0;
      stats_errs = 0;
      other_errs = 0;
      repeat (8) @(posedge clk_i);
      #1;
      reset_i = 1'b0;
      check_after_reset();
      run_single_frame();
      run_backpressure();
      check_cfg_rules();
      check_fifo_full();
      check_final_stats();
      $display("errors: beat %0d, cfg %0d, stats %0d, other %0d",
               beat_errs, cfg_errs, stats_errs, other_errs);
      if (beat_errs + cfg_errs + stats_errs + other_errs == 0) begin
         $display("PASS: all tests");
      end else begin
         $display("FAIL: see errors above");
      end
      $finish;
   end

endmodule
